// File: componentCount.f
+incdir+include
verilog/componentCountPkg.sv
verilog/firstBitFinder.sv
verilog/runExplorer.sv
verilog/loopDelay.sv
verilog/componentCountStage.sv
verilog/componentCountCore.sv
tb/componentCount_assertions.sv
tb/componentCount_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module componentCount_tb -Mdir obj_dir -f componentCount.f

output=$(./obj_dir/VcomponentCount_tb)
echo "$output"

if grep -qx "Test OK" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: tb/componentCount_tb.sv
`include "componentCount_params.svh"

module componentCount_tb
    import componentCountPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_IN_LATENCY = 1;
    localparam int TAGS = 1 << `TAG_WIDTH;
    localparam int TIMEOUT_CYCLES = 50000;

    logic clk = 1'b0;
    logic reset;
    logic request;
    graphT graphIn;
    logic graphValid;
    tagT tagIn;
    logic done;
    countT countOut;
    tagT tagOut;

    // Entries waiting for a request where a cleared valid flag marks an empty answer
    graphT graphQueue[$];
    tagT tagQueue[$];
    logic validQueue[$];

    int expected [TAGS];
    int returned [TAGS];
    int returnedCount [TAGS];
    int sentTotal;
    int doneTotal;
    int requestTotal;
    int errorCount;
    int checkCount;
    logic timedOut;
    logic respondEnable;
    logic [DATA_IN_LATENCY-1:0] requestHistory;
    logic [31:0] lfsrState;

    componentCountCore #(
        .DATA_IN_LATENCY(DATA_IN_LATENCY)
    ) i_componentCountCore (
        .clk(clk),
        .reset(reset),
        .request(request),
        .graphIn(graphIn),
        .graphValid(graphValid),
        .tagIn(tagIn),
        .done(done),
        .countOut(countOut),
        .tagOut(tagOut)
    );

    always #10 clk = ~clk;

    // Monitor and responder act just after each rising edge
    always @(posedge clk) begin
        #1;
        if (done) begin
            doneTotal++;
            if (expected[tagOut] < 0) begin
                errorCount++;
                $display("Result for tag %0d arrived but no graph with that tag is open", tagOut);
            end else begin
                returned[tagOut]++;
                returnedCount[tagOut] = countOut;
            end
        end
        if (request) begin
            requestTotal++;
        end
        // Answer the request seen DATA_IN_LATENCY cycles ago
        if (requestHistory[DATA_IN_LATENCY-1] && graphQueue.size() > 0) begin
            graphValid = validQueue.pop_front();
            graphIn = graphQueue.pop_front();
            tagIn = tagQueue.pop_front();
        end else begin
            graphValid = 1'b0;
            graphIn = '0;
            tagIn = '0;
        end
        requestHistory = (requestHistory << 1) | (request && respondEnable);
    end

    // Components in a chain are the 0 to 1 steps going up, with an empty node below bit 0
    function automatic int countRuns(graphT g);
        int runs;
        logic below;
        runs = 0;
        below = 1'b0;
        for (int n = 0; n < `GRAPH_WIDTH; n++) begin
            if (g[n] && !below) begin
                runs++;
            end
            below = g[n];
        end
        return runs;
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomGraph(output graphT g);
        for (int n = 0; n < `GRAPH_WIDTH; n++) begin
            lfsrState = lfsrNext(lfsrState);
            g[n] = lfsrState[0];
        end
    endtask

    task automatic checkValue(string testName, int expectedValue, int actualValue);
        checkCount++;
        if (expectedValue !== actualValue) begin
            errorCount++;
            $display("Mismatch in %s: expected %0d, actual %0d",
                testName, expectedValue, actualValue);
        end
    endtask

    task automatic queueGraph(graphT g, tagT t);
        expected[t] = countRuns(g);
        returned[t] = 0;
        graphQueue.push_back(g);
        tagQueue.push_back(t);
        validQueue.push_back(1'b1);
        sentTotal++;
    endtask

    task automatic queueEmptyAnswer();
        graphQueue.push_back('0);
        tagQueue.push_back('0);
        validQueue.push_back(1'b0);
    endtask

    task automatic clearResults();
        for (int t = 0; t < TAGS; t++) begin
            expected[t] = -1;
            returned[t] = 0;
        end
        sentTotal = 0;
        doneTotal = 0;
    endtask

    task automatic waitForResults(string testName);
        int cycles;
        cycles = 0;
        while (doneTotal < sentTotal && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (doneTotal < sentTotal) begin
            errorCount++;
            timedOut = 1'b1;
            $display("Timeout in %s: only %0d of %0d results arrived",
                testName, doneTotal, sentTotal);
        end
    endtask

    // Every open tag must come back exactly once with the model's count
    task automatic checkResults(string testName);
        for (int t = 0; t < TAGS; t++) begin
            if (expected[t] >= 0) begin
                checkValue($sformatf("%s tag %0d returns", testName, t), 1, returned[t]);
                checkValue($sformatf("%s tag %0d count", testName, t),
                    expected[t], returnedCount[t]);
            end
        end
    endtask

    task automatic idleRingTest();
        clearResults();
        requestTotal = 0;
        repeat (3 * `RING_PERIOD) @(posedge clk);
        // All slots are free, so each of them asks once per period
        checkValue("idle ring requests", 3 * `RING_PERIOD, requestTotal);
        checkValue("idle ring done pulses", 0, doneTotal);
    endtask

    task automatic fixedGraphTest();
        clearResults();
        queueGraph('0, 10'd1);
        queueGraph('1, 10'd2);
        queueGraph({32{2'b10}}, 10'd3);
        queueGraph({1'b1, 63'b0}, 10'd4);
        waitForResults("fixed graphs");
        checkResults("fixed graphs");
    endtask

    task automatic randomGraphTest();
        graphT g;
        clearResults();
        for (int i = 0; i < 200; i++) begin
            randomGraph(g);
            queueGraph(g, tagT'(i));
        end
        waitForResults("random graphs");
        checkResults("random graphs");
    endtask

    // Three graphs per slot, with run counts spread so results overtake each other
    task automatic busyRingTest();
        graphT g;
        clearResults();
        for (int i = 0; i < 3 * `RING_PERIOD; i++) begin
            g = '0;
            for (int j = 0; j < (i * 7) % 33; j++) begin
                g[2*j] = 1'b1;
            end
            queueGraph(g, tagT'(200 + i));
        end
        waitForResults("busy ring");
        checkResults("busy ring");
    endtask

    task automatic emptyAnswerTest();
        graphT g;
        clearResults();
        for (int i = 0; i < 20; i++) begin
            randomGraph(g);
            queueGraph(g, tagT'(300 + i));
            for (int k = 0; k < i % 3 + 1; k++) begin
                queueEmptyAnswer();
            end
        end
        waitForResults("empty answers");
        repeat (2 * `RING_PERIOD) @(posedge clk);
        checkValue("empty answers done pulses", sentTotal, doneTotal);
        checkResults("empty answers");
    endtask

    initial begin
        reset = 1'b1;
        graphIn = '0;
        graphValid = 1'b0;
        tagIn = '0;
        respondEnable = 1'b0;
        requestHistory = '0;
        lfsrState = 32'hdc0d_e53f;
        errorCount = 0;
        checkCount = 0;
        requestTotal = 0;
        timedOut = 1'b0;
        clearResults();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        respondEnable = 1'b1;
        idleRingTest();
        fixedGraphTest();
        if (!timedOut) begin
            randomGraphTest();
        end
        if (!timedOut) begin
            busyRingTest();
        end
        if (!timedOut) begin
            emptyAnswerTest();
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb/componentCount_assertions.sv
`include "componentCount_params.svh"

module componentCount_assertions
    import componentCountPkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  done,
    input countT countOut
);
    timeunit 1ns;
    timeprecision 1ps;

    // Counts cycles after reset and holds at one full ring period
    int unsigned sinceReset;

    always_ff @(posedge clk) begin
        if (reset) begin
            sinceReset <= 0;
        end else if (sinceReset < `RING_PERIOD) begin
            sinceReset <= sinceReset + 1;
        end
    end

    doneKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(done))
        else $error("done is unknown after reset");

    // No graph can finish a full trip this early
    quietAfterReset: assert property (@(posedge clk)
        (reset || sinceReset < `RING_PERIOD) |-> done !== 1'b1)
        else $error("done pulsed during reset or in the first ring period");

    countInRange: assert property (@(posedge clk) disable iff (reset)
        done |-> countOut <= `GRAPH_WIDTH / 2)
        else $error("count above the largest possible number of components");

endmodule

bind componentCountCore componentCount_assertions i_componentCountAssertions (
    .clk(clk),
    .reset(reset),
    .done(done),
    .countOut(countOut)
);

// File: verilog/componentCountCore.sv
`include "componentCount_params.svh"

module componentCountCore
    import componentCountPkg::*;
#(
    // Cycles from request to graph data with a minimum of 1
    parameter int DATA_IN_LATENCY = 1
) (
    input  logic  clk,
    input  logic  reset,
    output logic  request,
    input  graphT graphIn,
    input  logic  graphValid,
    input  tagT   tagIn,
    output logic  done,
    output countT countOut,
    output tagT   tagOut
);
    localparam int LOOP_DELAY = `RING_PERIOD - `STAGE_LATENCY;

    logic runEndIn;
    logic validLoopIn;
    graphT leftoverIn;
    countT countIn;
    tagT tagLoopIn;
    logic runEndOut;
    logic validLoopOut;
    graphT leftoverOut;
    countT countLoopOut;
    tagT tagLoopOut;

    logic [1:0] controlTap;
    logic [1:0] controlIn;

    componentCountStage i_componentCountStage (
        .clk(clk),
        .graphIn(graphIn),
        .graphValid(graphValid),
        .tagIn(tagIn),
        .runEndIn(runEndIn),
        .leftoverIn(leftoverIn),
        .countIn(countIn),
        .tagLoopIn(tagLoopIn),
        .validLoopIn(validLoopIn),
        .runEndOut(runEndOut),
        .leftoverOut(leftoverOut),
        .countOut(countLoopOut),
        .tagLoopOut(tagLoopOut),
        .validLoopOut(validLoopOut),
        .done(done),
        .resultCount(countOut),
        .resultTag(tagOut)
    );

    // Control line is split so request leads the stage input by DATA_IN_LATENCY
    loopDelay #(
        .CYCLES(LOOP_DELAY - DATA_IN_LATENCY),
        .WIDTH(2),
        .RESET_VALUE(2'b10)
    ) i_controlHeadDelay (
        .clk(clk),
        .reset(reset),
        .dataIn({runEndOut, validLoopOut}),
        .dataOut(controlTap)
    );

    loopDelay #(
        .CYCLES(DATA_IN_LATENCY),
        .WIDTH(2),
        .RESET_VALUE(2'b10)
    ) i_controlTailDelay (
        .clk(clk),
        .reset(reset),
        .dataIn(controlTap),
        .dataOut(controlIn)
    );

    assign request = controlTap[1];
    assign runEndIn = controlIn[1];
    assign validLoopIn = controlIn[0];

    loopDelay #(
        .CYCLES(LOOP_DELAY),
        .WIDTH(`GRAPH_WIDTH)
    ) i_leftoverDelay (
        .clk(clk),
        .reset(reset),
        .dataIn(leftoverOut),
        .dataOut(leftoverIn)
    );

    loopDelay #(
        .CYCLES(LOOP_DELAY),
        .WIDTH(`COUNT_WIDTH + `TAG_WIDTH)
    ) i_countTagDelay (
        .clk(clk),
        .reset(reset),
        .dataIn({countLoopOut, tagLoopOut}),
        .dataOut({countIn, tagLoopIn})
    );

endmodule

// File: verilog/componentCountStage.sv
`include "componentCount_params.svh"

module componentCountStage
    import componentCountPkg::*;
(
    input  logic  clk,
    input  graphT graphIn,
    input  logic  graphValid,
    input  tagT   tagIn,
    input  logic  runEndIn,
    input  graphT leftoverIn,
    input  countT countIn,
    input  tagT   tagLoopIn,
    input  logic  validLoopIn,
    output logic  runEndOut,
    output graphT leftoverOut,
    output countT countOut,
    output tagT   tagLoopOut,
    output logic  validLoopOut,
    output logic  done,
    output countT resultCount,
    output tagT   resultTag
);
    // Cycle at which the seed leaves the finder, and the reduced graph the explorer
    localparam int SEED_AT = 1 + `FINDER_LATENCY;
    localparam int REDUCED_AT = SEED_AT + `EXPLORER_LATENCY;

    graphT graphR [1:SEED_AT];
    countT countR [1:REDUCED_AT];
    tagT tagR [1:REDUCED_AT];
    logic validR [1:REDUCED_AT];
    logic incR [SEED_AT+1:REDUCED_AT];

    graphT seed;
    logic isEmpty;
    graphT reduced;

    firstBitFinder i_firstBitFinder (
        .clk(clk),
        .graphIn(graphR[1]),
        .firstBit(seed),
        .isEmpty(isEmpty)
    );

    // Component mask is not needed here, only what is left behind
    runExplorer i_runExplorer (
        .clk(clk),
        .seed(seed),
        .leftover(graphR[SEED_AT]),
        .extended(),
        .reduced(reduced)
    );

    always_ff @(posedge clk) begin
        // A free slot takes the new graph with a fresh count
        graphR[1] <= runEndIn ? (graphValid ? graphIn : '0) : leftoverIn;
        countR[1] <= runEndIn ? '0 : countIn;
        tagR[1] <= runEndIn ? tagIn : tagLoopIn;
        validR[1] <= runEndIn ? graphValid : validLoopIn;

        for (int i = 2; i <= SEED_AT; i++) begin
            graphR[i] <= graphR[i-1];
        end
        for (int i = 2; i <= REDUCED_AT; i++) begin
            countR[i] <= countR[i-1];
            tagR[i] <= tagR[i-1];
            validR[i] <= validR[i-1];
        end

        // Each pass with a seed finishes exactly one component
        incR[SEED_AT+1] <= !isEmpty;
        for (int i = SEED_AT + 2; i <= REDUCED_AT; i++) begin
            incR[i] <= incR[i-1];
        end

        runEndOut <= (reduced == '0);
        leftoverOut <= reduced;
        countOut <= countR[REDUCED_AT] + countT'(incR[REDUCED_AT]);
        tagLoopOut <= tagR[REDUCED_AT];
        validLoopOut <= validR[REDUCED_AT];
    end

    // A finished slot coming round reports the count it carried
    always_ff @(posedge clk) begin
        done <= runEndIn && validLoopIn;
        resultCount <= countIn;
        resultTag <= tagLoopIn;
    end

endmodule

// File: verilog/loopDelay.sv
module loopDelay #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] dataIn,
    output logic [WIDTH-1:0] dataOut
);
    logic [WIDTH-1:0] taps [CYCLES];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Every slot in the line comes out of reset with the same value
            for (int i = 0; i < CYCLES; i++) begin
                taps[i] <= RESET_VALUE;
            end
        end else begin
            taps[0] <= dataIn;
            for (int i = 1; i < CYCLES; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign dataOut = taps[CYCLES-1];

endmodule

// File: verilog/runExplorer.sv
`include "componentCount_params.svh"

module runExplorer
    import componentCountPkg::*;
(
    input  logic  clk,
    input  graphT seed,
    input  graphT leftover,
    output graphT extended,
    output graphT reduced
);
    // In one doubling step a node joins when it is set and the node s away is reached
    function automatic graphT spread(graphT g, graphT p, int unsigned s, logic up);
        graphT shifted;
        shifted = up ? (g << s) : (g >> s);
        return g | (p & shifted);
    endfunction

    // Nodes whose whole span of length 2s towards the seed side is set
    function automatic graphT spanMask(graphT p, int unsigned s, logic up);
        graphT shifted;
        shifted = up ? (p << s) : (p >> s);
        return p & shifted;
    endfunction

    graphT upG1;
    graphT upP1;
    graphT downG1;
    graphT downP1;
    graphT leftover1;
    graphT upG2;
    graphT upP2;
    graphT downG2;
    graphT downP2;
    graphT leftover2;
    graphT component;

    // Steps 1 and 2
    always_ff @(posedge clk) begin
        upG1 <= spread(spread(seed, leftover, 1, 1'b1), spanMask(leftover, 1, 1'b1), 2, 1'b1);
        upP1 <= spanMask(spanMask(leftover, 1, 1'b1), 2, 1'b1);
        downG1 <= spread(spread(seed, leftover, 1, 1'b0), spanMask(leftover, 1, 1'b0), 2, 1'b0);
        downP1 <= spanMask(spanMask(leftover, 1, 1'b0), 2, 1'b0);
        leftover1 <= leftover;
    end

    // Steps 4 and 8
    always_ff @(posedge clk) begin
        upG2 <= spread(spread(upG1, upP1, 4, 1'b1), spanMask(upP1, 4, 1'b1), 8, 1'b1);
        upP2 <= spanMask(spanMask(upP1, 4, 1'b1), 8, 1'b1);
        downG2 <= spread(spread(downG1, downP1, 4, 1'b0), spanMask(downP1, 4, 1'b0), 8, 1'b0);
        downP2 <= spanMask(spanMask(downP1, 4, 1'b0), 8, 1'b0);
        leftover2 <= leftover1;
    end

    // Steps 16 and 32 reach across the whole chain
    always_comb begin
        component = spread(spread(upG2, upP2, 16, 1'b1), spanMask(upP2, 16, 1'b1), 32, 1'b1)
            | spread(spread(downG2, downP2, 16, 1'b0), spanMask(downP2, 16, 1'b0), 32, 1'b0);
    end

    always_ff @(posedge clk) begin
        extended <= component;
        reduced <= leftover2 & ~component;
    end

endmodule

// File: verilog/firstBitFinder.sv
`include "componentCount_params.svh"

module firstBitFinder
    import componentCountPkg::*;
(
    input  logic  clk,
    input  graphT graphIn,
    output graphT firstBit,
    output logic  isEmpty
);
    localparam int GROUPS4 = `GRAPH_WIDTH / 4;
    localparam int GROUPS16 = GROUPS4 / 4;

    logic [GROUPS4-1:0] hasBit4;
    logic [GROUPS4-1:0] hasBit4D;
    logic [GROUPS16-1:0] hasBit16;
    graphT graphD1;
    graphT graphD2;

    // Set while nothing below this point holds a set bit
    logic [GROUPS16:0] clear16;
    logic [GROUPS4-1:0] clear4;
    graphT clearBit;

    always_ff @(posedge clk) begin
        for (int j = 0; j < GROUPS4; j++) begin
            hasBit4[j] <= |graphIn[4*j +: 4];
        end
        graphD1 <= graphIn;
        for (int k = 0; k < GROUPS16; k++) begin
            hasBit16[k] <= |hasBit4[4*k +: 4];
        end
        hasBit4D <= hasBit4;
        graphD2 <= graphD1;
    end

    // Prefix across the 16-node groups, then inside each group down to single bits
    always_comb begin
        clear16[0] = 1'b1;
        for (int k = 0; k < GROUPS16; k++) begin
            clear16[k+1] = clear16[k] & ~hasBit16[k];
        end
        for (int j = 0; j < GROUPS4; j++) begin
            if (j % 4 == 0) begin
                clear4[j] = clear16[j/4];
            end else begin
                clear4[j] = clear4[j-1] & ~hasBit4D[j-1];
            end
        end
        for (int n = 0; n < `GRAPH_WIDTH; n++) begin
            if (n % 4 == 0) begin
                clearBit[n] = clear4[n/4];
            end else begin
                clearBit[n] = clearBit[n-1] & ~graphD2[n-1];
            end
        end
    end

    assign firstBit = clearBit & graphD2;
    assign isEmpty = clear16[GROUPS16];

endmodule

// File: verilog/componentCountPkg.sv
`include "componentCount_params.svh"

package componentCountPkg;

    // Node mask where a set bit i means node i is present
    typedef logic [`GRAPH_WIDTH-1:0] graphT;

    // Number of components found so far in a slot
    typedef logic [`COUNT_WIDTH-1:0] countT;

    // Caller's label carried unchanged around the ring
    typedef logic [`TAG_WIDTH-1:0] tagT;

endpackage

// File: include/componentCount_params.svh
`ifndef COMPONENT_COUNT_PARAMS_SVH
`define COMPONENT_COUNT_PARAMS_SVH

// Graph size with one bit per node in a chain
`define GRAPH_WIDTH 64

// Enough for the alternating pattern, which has GRAPH_WIDTH/2 components
`define COUNT_WIDTH 6
`define TAG_WIDTH 10

// Pipeline depths in clock cycles
`define FINDER_LATENCY 2
`define EXPLORER_LATENCY 3
`define STAGE_LATENCY 7

// One full trip of a slot around the ring
`define RING_PERIOD 16

`endif
